/* verilog/rx_pkg.sv */
`default_nettype none

package rx_pkg;

    //////////////////////////////
    // Receive handler states
    //////////////////////////////
    typedef enum logic [1:0] {
        idle,
        push,
        drain
    } handler_state;

    //////////////////////////////
    // Host register offsets
    //////////////////////////////
    typedef enum logic [31:0] {
        CONTROL = 32'h0000_0000,
        STATUS  = 32'h0000_0004,
        DATA    = 32'h0000_0008
    } reg_addr;

    // Packet word is {slot[1:0], last, first, byte[7:0]}
    localparam int unsigned WORD_BITS = 12;

endpackage

`default_nettype wire

/* verilog/cycle_timer.sv */
`default_nettype none

module cycle_timer #(
    parameter int TIMEOUT_CYCLES = 15
) (
    input  logic clock,
    input  logic reset_n,
    input  logic load,
    output logic expired
);

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    logic [CNT_W-1:0] remaining;

    // Counts down after each load, sticks at zero
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= CNT_W'(TIMEOUT_CYCLES);
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    assign expired = (remaining == '0);

endmodule

`default_nettype wire

/* verilog/rx_slot_buffer.sv */
`default_nettype none

module rx_slot_buffer #(
    parameter int SLOT_DEPTH = 16
) (
    input  logic       clock,
    input  logic       reset_n,
    input  logic [7:0] slot_data,
    input  logic       slot_valid,
    output logic       slot_ready,
    output logic [7:0] byte_data,
    output logic       byte_present,
    input  logic       byte_take
);

    localparam int PTR_W = $clog2(SLOT_DEPTH);
    localparam int CNT_W = $clog2(SLOT_DEPTH + 1);

    logic [7:0]       mem [SLOT_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             wr_en;
    logic             rd_en;

    assign slot_ready   = (fill != CNT_W'(SLOT_DEPTH));
    assign byte_present = (fill != '0);
    assign byte_data    = mem[rd_ptr];

    assign wr_en = slot_valid && slot_ready;
    assign rd_en = byte_take && byte_present;

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= slot_data;
        end
    end

    // Pointers wrap at SLOT_DEPTH, which need not be a power of two
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(SLOT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(SLOT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill <= fill + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

endmodule

`default_nettype wire

/* verilog/slot_receive_handler.sv */
`default_nettype none

module slot_receive_handler #(
    parameter int SLOTS          = 4,
    parameter int TIMEOUT_CYCLES = 15
) (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    run,
    input  logic                    room,
    input  logic [SLOTS-1:0][7:0]   byte_data,
    input  logic [SLOTS-1:0]        byte_present,
    output logic [SLOTS-1:0]        byte_take,
    output logic [7:0]              push_byte,
    output logic                    push_first,
    output logic [1:0]              push_slot,
    output logic                    push_valid,
    output logic                    push_last,
    output rx_pkg::handler_state    state
);

    // Slot field width follows the packet word layout
    localparam int SLOT_BITS = rx_pkg::WORD_BITS - 10;

    logic [SLOT_BITS-1:0] scan;
    logic [SLOT_BITS-1:0] scan_next;
    logic                 first_pend;
    logic                 hit;
    logic                 take;
    logic                 timer_load;
    logic                 timer_expired;

    cycle_timer #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) idle_timer (
        .clock   (clock),
        .reset_n (reset_n),
        .load    (timer_load),
        .expired (timer_expired)
    );

    //////////////////////////////
    // Scan and take decisions
    //////////////////////////////
    assign scan_next = (scan == SLOT_BITS'(SLOTS - 1)) ? '0 : scan + 1'b1;
    assign hit       = run && byte_present[scan];
    assign take      = (state == rx_pkg::push) && run && room && byte_present[scan];
    assign byte_take = take ? (SLOTS'(1) << scan) : '0;

    // Reload on entry, on each byte, and while the FIFO is short of room
    assign timer_load = ((state == rx_pkg::idle) && hit) || take ||
                        ((state == rx_pkg::push) && !room);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state      <= rx_pkg::idle;
            scan       <= '0;
            first_pend <= 1'b0;
            push_valid <= 1'b0;
            push_last  <= 1'b0;
        end else begin
            push_valid <= take;
            push_last  <= 1'b0;
            if (take) begin
                first_pend <= 1'b0;
            end
            case (state)
                rx_pkg::idle: begin
                    if (hit) begin
                        state      <= rx_pkg::push;
                        first_pend <= 1'b1;
                    end else begin
                        scan <= scan_next;
                    end
                end
                rx_pkg::push: begin
                    if (!take && timer_expired) begin
                        state <= rx_pkg::drain;
                    end
                end
                rx_pkg::drain: begin
                    // Close the packet and move on to the next slot
                    push_last <= 1'b1;
                    scan      <= scan_next;
                    state     <= rx_pkg::idle;
                end
                default: begin
                    state <= rx_pkg::idle;
                end
            endcase
        end
    end

    // Payload of the forwarded byte
    always_ff @(posedge clock) begin
        if (take) begin
            push_byte  <= byte_data[scan];
            push_first <= first_pend;
            push_slot  <= 2'(scan);
        end
    end

endmodule

`default_nettype wire

/* verilog/packet_fifo.sv */
`default_nettype none

module packet_fifo #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic [7:0]                   push_byte,
    input  logic                         push_first,
    input  logic [1:0]                   push_slot,
    input  logic                         push_valid,
    input  logic                         push_last,
    output logic                         room,
    output logic [rx_pkg::WORD_BITS-1:0] word,
    output logic                         not_empty,
    output logic [7:0]                   count,
    input  logic                         pop
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [rx_pkg::WORD_BITS-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]             wr_ptr;
    logic [PTR_W-1:0]             rd_ptr;
    logic [CNT_W-1:0]             store_count;
    logic                         hold_valid;
    logic [7:0]                   hold_byte;
    logic                         hold_first;
    logic [1:0]                   hold_slot;
    logic                         wr_en;
    logic                         rd_en;

    // Held word leaves once the next word or the packet end shows up
    assign wr_en = hold_valid && (push_valid || push_last);
    assign rd_en = pop && not_empty;

    // Hold stage counts as occupied so one more push always fits
    assign room = (32'(store_count) + 32'(hold_valid) + 32'd2) <= 32'(FIFO_DEPTH);

    assign word      = mem[rd_ptr];
    assign not_empty = (store_count != '0);
    assign count     = 8'(store_count);

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= {hold_slot, push_last, hold_first, hold_byte};
        end
        if (push_valid) begin
            hold_byte  <= push_byte;
            hold_first <= push_first;
            hold_slot  <= push_slot;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            hold_valid  <= 1'b0;
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            store_count <= '0;
        end else begin
            if (push_valid) begin
                hold_valid <= 1'b1;
            end else if (push_last) begin
                hold_valid <= 1'b0;
            end
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            store_count <= store_count + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

endmodule

`default_nettype wire

/* verilog/axil_packet_reader.sv */
`default_nettype none

module axil_packet_reader (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic [31:0]                  awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [31:0]                  wdata,
    input  logic [3:0]                   wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  logic [31:0]                  araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [31:0]                  rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready,
    output logic                         run,
    input  logic [rx_pkg::WORD_BITS-1:0] word,
    input  logic                         not_empty,
    input  logic [7:0]                   count,
    output logic                         pop
);

    logic [31:0] aw_addr;
    logic        aw_hold;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic        w_hold;
    logic [31:0] read_value;

    // Always OKAY, unknown offsets included
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    //////////////////////////////
    // Write channels
    //////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            aw_hold <= 1'b0;
            w_hold  <= 1'b0;
            bvalid  <= 1'b0;
            run     <= 1'b0;
        end else begin
            if (awready && awvalid) begin
                awready <= 1'b0;
                aw_hold <= 1'b1;
            end else if (!aw_hold && !bvalid) begin
                awready <= 1'b1;
            end
            if (wready && wvalid) begin
                wready <= 1'b0;
                w_hold <= 1'b1;
            end else if (!w_hold && !bvalid) begin
                wready <= 1'b1;
            end
            if (bvalid && bready) begin
                bvalid  <= 1'b0;
                aw_hold <= 1'b0;
                w_hold  <= 1'b0;
            end else if (aw_hold && w_hold && !bvalid) begin
                bvalid <= 1'b1;
                if (aw_addr == rx_pkg::CONTROL && w_strb[0]) begin
                    run <= w_data[0];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (awready && awvalid) begin
            aw_addr <= awaddr;
        end
        if (wready && wvalid) begin
            w_data <= wdata;
            w_strb <= wstrb;
        end
    end

    //////////////////////////////
    // Read channels
    //////////////////////////////
    always_comb begin
        read_value = '0;
        case (araddr)
            rx_pkg::CONTROL: read_value = {31'b0, run};
            rx_pkg::STATUS:  read_value = {16'b0, count, 7'b0, not_empty};
            rx_pkg::DATA: begin
                // Slot bits move up to 13:12
                if (not_empty) begin
                    read_value = {18'b0, word[11:10], 2'b0, word[9:0]};
                end
            end
            default: read_value = '0;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            pop     <= 1'b0;
        end else begin
            pop <= 1'b0;
            if (arvalid && arready) begin
                arready <= 1'b0;
                rvalid  <= 1'b1;
                pop     <= (araddr == rx_pkg::DATA) && not_empty;
            end else begin
                if (rvalid && rready) begin
                    rvalid <= 1'b0;
                end
                if (!rvalid && !arready) begin
                    arready <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (arvalid && arready) begin
            rdata <= read_value;
        end
    end

endmodule

`default_nettype wire

/* verilog/rx_gather_top.sv */
`default_nettype none

module rx_gather_top #(
    parameter int SLOTS          = 4,
    parameter int SLOT_DEPTH     = 16,
    parameter int FIFO_DEPTH     = 32,
    parameter int TIMEOUT_CYCLES = 15
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic [SLOTS-1:0][7:0] slot_data,
    input  logic [SLOTS-1:0]      slot_valid,
    output logic [SLOTS-1:0]      slot_ready,
    input  logic [31:0]           awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [31:0]           araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready
);

    logic [SLOTS-1:0][7:0]        byte_data;
    logic [SLOTS-1:0]             byte_present;
    logic [SLOTS-1:0]             byte_take;
    logic [7:0]                   push_byte;
    logic                         push_first;
    logic [1:0]                   push_slot;
    logic                         push_valid;
    logic                         push_last;
    logic                         room;
    logic                         run;
    logic [rx_pkg::WORD_BITS-1:0] word;
    logic                         not_empty;
    logic [7:0]                   count;
    logic                         pop;

    //////////////////////////////
    // Input side
    //////////////////////////////
    for (genvar s = 0; s < SLOTS; s++) begin : g_slot
        rx_slot_buffer #(
            .SLOT_DEPTH (SLOT_DEPTH)
        ) slot_buffer (
            .clock        (clock),
            .reset_n      (reset_n),
            .slot_data    (slot_data[s]),
            .slot_valid   (slot_valid[s]),
            .slot_ready   (slot_ready[s]),
            .byte_data    (byte_data[s]),
            .byte_present (byte_present[s]),
            .byte_take    (byte_take[s])
        );
    end

    slot_receive_handler #(
        .SLOTS          (SLOTS),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) handler (
        .clock        (clock),
        .reset_n      (reset_n),
        .run          (run),
        .room         (room),
        .byte_data    (byte_data),
        .byte_present (byte_present),
        .byte_take    (byte_take),
        .push_byte    (push_byte),
        .push_first   (push_first),
        .push_slot    (push_slot),
        .push_valid   (push_valid),
        .push_last    (push_last),
        .state        ()
    );

    //////////////////////////////
    // Output side
    //////////////////////////////
    packet_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo (
        .clock      (clock),
        .reset_n    (reset_n),
        .push_byte  (push_byte),
        .push_first (push_first),
        .push_slot  (push_slot),
        .push_valid (push_valid),
        .push_last  (push_last),
        .room       (room),
        .word       (word),
        .not_empty  (not_empty),
        .count      (count),
        .pop        (pop)
    );

    axil_packet_reader reader (
        .clock     (clock),
        .reset_n   (reset_n),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .run       (run),
        .word      (word),
        .not_empty (not_empty),
        .count     (count),
        .pop       (pop)
    );

endmodule

`default_nettype wire

/* bench/rx_gather_chk.sv */
`default_nettype none

module rx_gather_chk #(
    parameter int SLOTS = 4
) (
    input logic                 clock,
    input logic                 reset_n,
    input logic [SLOTS-1:0]     byte_take,
    input logic [SLOTS-1:0]     byte_present,
    input logic                 push_valid,
    input logic                 push_last,
    input rx_pkg::handler_state state,
    input logic                 fifo_write,
    input logic                 fifo_full
);

    //////////////////////////////
    // Handler pops
    //////////////////////////////
    take_onehot: assert property (@(posedge clock) disable iff (!reset_n)
        $onehot0(byte_take))
        else $error("byte_take selects more than one slot");

    take_present: assert property (@(posedge clock) disable iff (!reset_n)
        (byte_take & ~byte_present) == '0)
        else $error("byte_take on a slot with no byte present");

    //////////////////////////////
    // Push side
    //////////////////////////////
    push_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
        !(push_valid && push_last))
        else $error("push_valid and push_last in the same cycle");

    // A forwarded byte always comes from a visit in progress
    push_not_idle: assert property (@(posedge clock) disable iff (!reset_n)
        push_valid |-> (state != rx_pkg::idle))
        else $error("handler pushed a byte while idle");

    write_not_full: assert property (@(posedge clock) disable iff (!reset_n)
        !(fifo_write && fifo_full))
        else $error("packet FIFO written while full");

endmodule

bind slot_receive_handler rx_gather_chk #(
    .SLOTS (SLOTS)
) handler_chk (
    .clock        (clock),
    .reset_n      (reset_n),
    .byte_take    (byte_take),
    .byte_present (byte_present),
    .push_valid   (push_valid),
    .push_last    (push_last),
    .state        (state),
    .fifo_write   (1'b0),
    .fifo_full    (1'b0)
);

bind packet_fifo rx_gather_chk #(
    .SLOTS (1)
) fifo_chk (
    .clock        (clock),
    .reset_n      (reset_n),
    .byte_take    (1'b0),
    .byte_present (1'b0),
    .push_valid   (push_valid),
    .push_last    (push_last),
    .state        (rx_pkg::push),
    .fifo_write   (wr_en),
    .fifo_full    (32'(store_count) == FIFO_DEPTH)
);

`default_nettype wire

/* bench/rx_gather_tb.sv */
`default_nettype none

module rx_gather_tb;

    localparam int SLOTS          = 4;
    localparam int SLOT_DEPTH     = 16;
    localparam int FIFO_DEPTH     = 32;
    localparam int TIMEOUT_CYCLES = 15;

    // Ten bursts over all tests, each with its idle tail
    localparam int BURSTS       = 10;
    localparam int STIM_CYCLES  = BURSTS * (SLOT_DEPTH + 3 * TIMEOUT_CYCLES);
    localparam int DRAIN_CYCLES = BURSTS * SLOT_DEPTH * 16;
    localparam int CYCLE_LIMIT  = 2 * STIM_CYCLES + DRAIN_CYCLES;

    logic                  clock;
    logic                  reset_n;
    logic [SLOTS-1:0][7:0] slot_data;
    logic [SLOTS-1:0]      slot_valid;
    logic [SLOTS-1:0]      slot_ready;
    logic [31:0]           awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [31:0]           wdata;
    logic [3:0]            wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [31:0]           araddr;
    logic                  arvalid;
    logic                  arready;
    logic [31:0]           rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    logic [7:0]  burst_q [SLOTS][$];
    logic [31:0] expected_q [SLOTS][$];
    int          open_slot = -1;
    int          sends_done;
    int          cycle_count = 0;
    logic [31:0] value;

    rx_gather_top #(
        .SLOTS          (SLOTS),
        .SLOT_DEPTH     (SLOT_DEPTH),
        .FIFO_DEPTH     (FIFO_DEPTH),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) i_rx_gather_top (
        .clock (clock), .reset_n (reset_n),
        .slot_data (slot_data), .slot_valid (slot_valid), .slot_ready (slot_ready),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    //////////////////////////////
    // Failure reporting
    //////////////////////////////
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            stop_with_failure("Value mismatch");
        end
    endtask

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            stop_with_failure($sformatf("Run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////
    // Expected DATA register value for every byte of one burst
    function automatic void expect_burst(input int slot, input logic [7:0] burst [$]);
        logic first;
        logic last;
        for (int i = 0; i < burst.size(); i++) begin
            first = (i == 0);
            last  = (i == burst.size() - 1);
            expected_q[slot].push_back({18'b0, 2'(slot), 2'b0, last, first, burst[i]});
        end
    endfunction

    function automatic int queued_words();
        int total;
        total = 0;
        for (int s = 0; s < SLOTS; s++) begin
            total += expected_q[s].size();
        end
        return total;
    endfunction

    task automatic make_burst(input int slot, input int len);
        burst_q[slot].delete();
        for (int i = 0; i < len; i++) begin
            burst_q[slot].push_back(8'($urandom));
        end
        expect_burst(slot, burst_q[slot]);
    endtask

    //////////////////////////////
    // Slot and host drivers
    //////////////////////////////
    task automatic send_burst(input int slot);
        @(negedge clock);
        for (int i = 0; i < burst_q[slot].size(); i++) begin
            slot_data[slot]  = burst_q[slot][i];
            slot_valid[slot] = 1'b1;
            // Ready is stable between the edges
            while (!slot_ready[slot]) begin
                @(negedge clock);
            end
            @(negedge clock);
        end
        slot_valid[slot] = 1'b0;
        repeat (3 * TIMEOUT_CYCLES) @(negedge clock);
    endtask

    task automatic launch_all_slots();
        sends_done = 0;
        for (int s = 0; s < SLOTS; s++) begin
            fork
                automatic int k = s;
                begin
                    send_burst(k);
                    sends_done++;
                end
            join_none
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        logic aw_done;
        logic w_done;
        logic aw_hit;
        logic w_hit;
        @(negedge clock);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = 4'hf;
        wvalid  = 1'b1;
        bready  = 1'b1;
        aw_done = 1'b0;
        w_done  = 1'b0;
        while (!aw_done || !w_done) begin
            aw_hit = awvalid && awready;
            w_hit  = wvalid && wready;
            @(negedge clock);
            if (aw_hit) begin
                awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_hit) begin
                wvalid = 1'b0;
                w_done = 1'b1;
            end
        end
        while (!bvalid) begin
            @(negedge clock);
        end
        compare_value("bresp", 32'(bresp), 32'd0);
        @(negedge clock);
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clock);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        while (!arready) begin
            @(negedge clock);
        end
        @(negedge clock);
        arvalid = 1'b0;
        while (!rvalid) begin
            @(negedge clock);
        end
        data = rdata;
        compare_value("rresp", 32'(rresp), 32'd0);
        @(negedge clock);
        rready = 1'b0;
    endtask

    //////////////////////////////
    // Compare process
    //////////////////////////////
    task automatic wait_for_count(input int words);
        logic [31:0] status;
        do begin
            read_reg(rx_pkg::STATUS, status);
        end while (32'(status[15:8]) != words);
    endtask

    task automatic drain_and_compare(input bit check_count);
        logic [31:0] status;
        logic [31:0] got;
        logic [31:0] exp;
        int          slot;
        while (queued_words() != 0) begin
            read_reg(rx_pkg::STATUS, status);
            if (check_count) begin
                compare_value("status count", 32'(status[15:8]), 32'(queued_words()));
            end
            if (status[0]) begin
                read_reg(rx_pkg::DATA, got);
                slot = int'(got[13:12]);
                if (slot >= SLOTS || expected_q[slot].size() == 0) begin
                    stop_with_failure($sformatf("Word %h came from slot %0d with nothing pending",
                                                got, slot));
                end
                exp = expected_q[slot].pop_front();
                // Packets never mix slots
                if (open_slot >= 0) begin
                    compare_value("packet slot", 32'(slot), 32'(open_slot));
                end
                compare_value("data byte", 32'(got[7:0]), 32'(exp[7:0]));
                compare_value("first flag", 32'(got[8]), 32'(exp[8]));
                compare_value("last flag", 32'(got[9]), 32'(exp[9]));
                compare_value("data word", got, exp);
                open_slot = got[9] ? -1 : slot;
            end
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        reset_n    = 1'b0;
        slot_data  = '0;
        slot_valid = '0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        void'($urandom(32'hd2f0));
        repeat (3) @(negedge clock);
        reset_n = 1'b1;

        // Registers out of reset
        read_reg(rx_pkg::STATUS, value);
        compare_value("status after reset", value, 32'd0);
        read_reg(rx_pkg::CONTROL, value);
        compare_value("control after reset", value, 32'd0);
        read_reg(rx_pkg::DATA, value);
        compare_value("data after reset", value, 32'd0);
        write_reg(rx_pkg::CONTROL, 32'd1);
        read_reg(rx_pkg::CONTROL, value);
        compare_value("control run", value, 32'd1);

        // Single burst on one slot
        make_burst(1, 1 + int'($urandom % SLOT_DEPTH));
        send_burst(1);
        wait_for_count(queued_words());
        drain_and_compare(1'b1);

        // All slots at once, read while traffic runs
        for (int s = 0; s < SLOTS; s++) begin
            make_burst(s, 1 + int'($urandom % SLOT_DEPTH));
        end
        launch_all_slots();
        drain_and_compare(1'b0);
        wait (sends_done == SLOTS);

        // Bytes wait in the slot buffer while stopped
        write_reg(rx_pkg::CONTROL, 32'd0);
        make_burst(2, 1 + int'($urandom % SLOT_DEPTH));
        send_burst(2);
        read_reg(rx_pkg::STATUS, value);
        compare_value("status while stopped", value, 32'd0);
        write_reg(rx_pkg::CONTROL, 32'd1);
        wait_for_count(queued_words());
        drain_and_compare(1'b1);

        // Back-pressure with the host not reading
        for (int s = 0; s < SLOTS; s++) begin
            make_burst(s, SLOT_DEPTH);
        end
        launch_all_slots();
        wait (sends_done == SLOTS);
        @(negedge clock);
        if (&slot_ready) begin
            stop_with_failure("No slot dropped slot_ready with the packet FIFO full");
        end
        drain_and_compare(1'b0);
        read_reg(rx_pkg::STATUS, value);
        compare_value("status at end", value, 32'd0);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
verilog/rx_pkg.sv
verilog/cycle_timer.sv
verilog/rx_slot_buffer.sv
verilog/slot_receive_handler.sv
verilog/packet_fifo.sv
verilog/axil_packet_reader.sv
verilog/rx_gather_top.sv
bench/rx_gather_chk.sv
bench/rx_gather_tb.sv

/* Makefile */
TOP = rx_gather_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --top-module $(TOP) -f verilog.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation passed$$" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir sim.log
